//--- verilog/alu_macros.svh
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Data word width of the shared bus
`define ALU_WIDTH 32

// Non-restoring iterations, one per quotient bit
`define DIV_STEPS 32

// Shift amount bits taken from the bus operand
`define SHAMT_W 5

`endif

//--- verilog/alu_types_pkg.sv
`default_nettype none

`include "alu_macros.svh"

package alu_types_pkg;

	// One bus value
	typedef logic [`ALU_WIDTH-1:0] word_t;

	// Full product, or remainder and quotient side by side
	typedef logic [2*`ALU_WIDTH-1:0] dword_t;

	// Opcode set, same encoding as the control unit
	typedef enum logic [3:0] {
		OP_AND  = 4'd0,
		OP_OR   = 4'd1,
		OP_NEG  = 4'd2,
		OP_NOT  = 4'd3,
		OP_ADD  = 4'd4,
		OP_SUB  = 4'd5,
		OP_MUL  = 4'd6,
		OP_DIV  = 4'd7,
		OP_SHR  = 4'd8,
		OP_SHRA = 4'd9,
		OP_SHL  = 4'd10,
		OP_ROR  = 4'd11,
		OP_ROL  = 4'd12
	} alu_op_t;

	// Operands frozen at start
	typedef struct packed {
		alu_op_t op;
		word_t   y;
		word_t   b;
	} operand_s;

endpackage

`default_nettype wire

//--- verilog/alu_ctrl_pkg.sv
`default_nettype none

package alu_ctrl_pkg;

	// Divider sequencing
	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_PREP,
		DIV_ITER,
		DIV_FIX
	} div_state_t;

	// Z value as two bus words
	// hi gets the product top or the remainder
	typedef struct packed {
		alu_types_pkg::word_t hi;
		alu_types_pkg::word_t lo;
	} result_s;

endpackage

`default_nettype wire

//--- verilog/operand_stage.sv
`timescale 1ns/1ps
`default_nettype none

module operand_stage (
	input  wire                          clock,
	input  wire                          rst_n,
	input  wire alu_types_pkg::word_t    bus,
	input  wire                          y_in,
	input  wire                          start,
	input  wire alu_types_pkg::alu_op_t  op,
	input  wire                          busy,
	output alu_types_pkg::operand_s      opnd,
	output logic                         opnd_valid
);

	alu_types_pkg::word_t y_q;
	logic take;

	// A start during busy is dropped
	assign take = start && !busy;

	// Y register, old value still seen by a start in the same cycle
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			y_q <= '0;
		end else if (y_in) begin
			y_q <= bus;
		end
	end

	// One-cycle launch toward the ALU
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			opnd_valid <= 1'b0;
		end else begin
			opnd_valid <= take;
		end
	end

	// Operand record held until the next accepted start
	always_ff @(posedge clock) begin
		if (take) begin
			opnd.op <= op;
			opnd.y  <= y_q;
			opnd.b  <= bus;
		end
	end

	// Busy comes back from the ALU
	a_no_start_busy: assert property (@(posedge clock) disable iff (!rst_n)
		start |-> !busy)
		else $error("start pulse while ALU busy");

endmodule

`default_nettype wire

//--- verilog/bit_pair_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module bit_pair_multiplier (
	input  wire alu_types_pkg::word_t  y,
	input  wire alu_types_pkg::word_t  b,
	output alu_types_pkg::dword_t      product
);

	// Two multiplier bits per Booth digit
	localparam int DIGITS = `ALU_WIDTH / 2;

	logic [`ALU_WIDTH:0] b_ext;
	alu_types_pkg::dword_t y_ext;
	alu_types_pkg::dword_t y_ext2;
	logic [2:0] group [DIGITS];
	alu_types_pkg::dword_t pp [DIGITS];

	// Implicit zero below the LSB
	assign b_ext = {b, 1'b0};

	// Multiplicand sign extended to product width
	assign y_ext  = {{`ALU_WIDTH{y[`ALU_WIDTH-1]}}, y};
	assign y_ext2 = y_ext << 1;

	// Overlapping triplets
	for (genvar g = 0; g < DIGITS; g++) begin : g_recode
		assign group[g] = b_ext[2*g+2 -: 3];
	end

	// Digit in {-2,-1,0,+1,+2}
	always_comb begin
		for (int i = 0; i < DIGITS; i++) begin
			case (group[i])
				3'b001, 3'b010: pp[i] = y_ext;
				3'b011:         pp[i] = y_ext2;
				3'b100:         pp[i] = -y_ext2;
				3'b101, 3'b110: pp[i] = -y_ext;
				default:        pp[i] = '0;
			endcase
		end
	end

	// Weighted sum, wraps mod 2^64
	always_comb begin
		product = '0;
		for (int i = 0; i < DIGITS; i++) begin
			product = product + (pp[i] << (2 * i));
		end
	end

endmodule

`default_nettype wire

//--- verilog/nonrestoring_divider.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module nonrestoring_divider (
	input  wire                        clock,
	input  wire                        rst_n,
	input  wire                        go,
	input  wire alu_types_pkg::word_t  dividend,
	input  wire alu_types_pkg::word_t  divisor,
	output alu_types_pkg::word_t       quotient,
	output alu_types_pkg::word_t       remainder,
	output logic                       fin
);

	localparam int W = `ALU_WIDTH;
	localparam int CNT_W = $clog2(`DIV_STEPS);

	alu_ctrl_pkg::div_state_t state;
	logic [CNT_W-1:0] count;
	alu_types_pkg::word_t a_q;
	alu_types_pkg::word_t b_q;
	alu_types_pkg::word_t a_mag;
	alu_types_pkg::word_t b_mag;
	alu_types_pkg::word_t q_q;
	logic [W:0] d_q;
	logic [W:0] r_q;
	logic [W:0] r_shift;
	logic [W:0] r_step;
	logic [W:0] r_fix;
	logic neg_q;
	logic neg_r;
	logic by_zero;

	// Magnitudes of both operands
	// 2^31 still fits as an unsigned magnitude
	assign a_mag = a_q[W-1] ? -a_q : a_q;
	assign b_mag = b_q[W-1] ? -b_q : b_q;

	// Shift in next dividend bit, then add or subtract by remainder sign
	assign r_shift = {r_q[W-1:0], q_q[W-1]};
	assign r_step  = r_q[W] ? r_shift + d_q : r_shift - d_q;

	// Final correction of a negative remainder
	assign r_fix = r_q[W] ? r_q + d_q : r_q;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= alu_ctrl_pkg::DIV_IDLE;
			count <= '0;
		end else begin
			case (state)
				alu_ctrl_pkg::DIV_IDLE: begin
					if (go) begin
						state <= alu_ctrl_pkg::DIV_PREP;
					end
				end
				alu_ctrl_pkg::DIV_PREP: begin
					state <= alu_ctrl_pkg::DIV_ITER;
					count <= '0;
				end
				alu_ctrl_pkg::DIV_ITER: begin
					count <= count + 1'b1;
					if (count == CNT_W'(`DIV_STEPS - 1)) begin
						state <= alu_ctrl_pkg::DIV_FIX;
					end
				end
				default: state <= alu_ctrl_pkg::DIV_IDLE;
			endcase
		end
	end

	// Datapath registers
	always_ff @(posedge clock) begin
		case (state)
			alu_ctrl_pkg::DIV_IDLE: begin
				if (go) begin
					a_q <= dividend;
					b_q <= divisor;
				end
			end
			alu_ctrl_pkg::DIV_PREP: begin
				q_q     <= a_mag;
				d_q     <= {1'b0, b_mag};
				r_q     <= '0;
				neg_q   <= a_q[W-1] ^ b_q[W-1];
				neg_r   <= a_q[W-1];
				by_zero <= (b_q == '0);
			end
			alu_ctrl_pkg::DIV_ITER: begin
				r_q <= r_step;
				// Quotient bit is 1 when the new remainder stays non-negative
				q_q <= {q_q[W-2:0], ~r_step[W]};
			end
			default: begin
			end
		endcase
	end

	// Signs applied during FIX for truncation toward zero
	assign quotient  = by_zero ? '1 : (neg_q ? -q_q : q_q);
	assign remainder = by_zero ? a_q : (neg_r ? -r_fix[W-1:0] : r_fix[W-1:0]);
	assign fin = (state == alu_ctrl_pkg::DIV_FIX);

	a_go_idle: assert property (@(posedge clock) disable iff (!rst_n)
		go |-> state == alu_ctrl_pkg::DIV_IDLE)
		else $error("divider launched while not idle");

	// One fin pulse right after the last step
	a_fin_pulse: assert property (@(posedge clock) disable iff (!rst_n)
		go |-> ##(`DIV_STEPS + 2) fin ##1 !fin)
		else $error("divider fin not a single pulse after the last step");

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu (
	input  wire                            clock,
	input  wire                            rst_n,
	input  wire alu_types_pkg::operand_s   opnd,
	input  wire                            opnd_valid,
	output alu_ctrl_pkg::result_s          res,
	output logic                           res_valid,
	output logic                           busy
);

	logic [`SHAMT_W-1:0] shamt;
	alu_types_pkg::dword_t product;
	alu_types_pkg::word_t quotient;
	alu_types_pkg::word_t remainder;
	logic is_div;
	logic div_go;
	logic div_fin;
	logic div_pending;

	// AND, OR, and the unary ops on y
	function automatic alu_types_pkg::word_t logic_unit(
		input alu_types_pkg::alu_op_t op,
		input alu_types_pkg::word_t   y,
		input alu_types_pkg::word_t   b
	);
		case (op)
			alu_types_pkg::OP_AND: return y & b;
			alu_types_pkg::OP_OR:  return y | b;
			alu_types_pkg::OP_NEG: return -y;
			alu_types_pkg::OP_NOT: return ~y;
			default:               return '0;
		endcase
	endfunction

	// Subtract as add of inverted b with carry in
	function automatic alu_types_pkg::word_t add_sub(
		input alu_types_pkg::word_t a,
		input alu_types_pkg::word_t b,
		input logic                 sub
	);
		alu_types_pkg::word_t bx;
		bx = sub ? ~b : b;
		return a + bx + {{(`ALU_WIDTH-1){1'b0}}, sub};
	endfunction

	// Shifts, plus rotates through a doubled word
	function automatic alu_types_pkg::word_t shift_rot(
		input alu_types_pkg::alu_op_t op,
		input alu_types_pkg::word_t   y,
		input logic [`SHAMT_W-1:0]    sh
	);
		alu_types_pkg::dword_t dbl;
		alu_types_pkg::dword_t right;
		alu_types_pkg::dword_t left;
		dbl   = {y, y};
		right = dbl >> sh;
		left  = dbl << sh;
		case (op)
			alu_types_pkg::OP_SHR:  return y >> sh;
			alu_types_pkg::OP_SHRA: return $signed(y) >>> sh;
			alu_types_pkg::OP_SHL:  return y << sh;
			alu_types_pkg::OP_ROR:  return right[`ALU_WIDTH-1:0];
			alu_types_pkg::OP_ROL:  return left[2*`ALU_WIDTH-1:`ALU_WIDTH];
			default:                return '0;
		endcase
	endfunction

	// Only the low bits of b count
	assign shamt = opnd.b[`SHAMT_W-1:0];

	bit_pair_multiplier u_mul (
		.y       (opnd.y),
		.b       (opnd.b),
		.product (product)
	);

	nonrestoring_divider u_div (
		.clock     (clock),
		.rst_n     (rst_n),
		.go        (div_go),
		.dividend  (opnd.y),
		.divisor   (opnd.b),
		.quotient  (quotient),
		.remainder (remainder),
		.fin       (div_fin)
	);

	// Opcode decode, hi is zero except MUL and DIV
	always_comb begin
		res = '0;
		if (div_fin) begin
			res.hi = remainder;
			res.lo = quotient;
		end else begin
			case (opnd.op)
				alu_types_pkg::OP_AND, alu_types_pkg::OP_OR,
				alu_types_pkg::OP_NEG, alu_types_pkg::OP_NOT:
					res.lo = logic_unit(opnd.op, opnd.y, opnd.b);
				alu_types_pkg::OP_ADD: res.lo = add_sub(opnd.y, opnd.b, 1'b0);
				alu_types_pkg::OP_SUB: res.lo = add_sub(opnd.y, opnd.b, 1'b1);
				alu_types_pkg::OP_MUL: res = alu_ctrl_pkg::result_s'(product);
				alu_types_pkg::OP_SHR, alu_types_pkg::OP_SHRA, alu_types_pkg::OP_SHL,
				alu_types_pkg::OP_ROR, alu_types_pkg::OP_ROL:
					res.lo = shift_rot(opnd.op, opnd.y, shamt);
				// Undefined codes fall through as zero
				default: res = '0;
			endcase
		end
	end

	// Single-cycle ops answer at once, DIV answers on fin
	assign is_div    = (opnd.op == alu_types_pkg::OP_DIV);
	assign div_go    = opnd_valid && is_div;
	assign res_valid = (opnd_valid && !is_div) || div_fin;
	assign busy      = opnd_valid || div_pending;

	// Division in flight
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			div_pending <= 1'b0;
		end else if (div_go) begin
			div_pending <= 1'b1;
		end else if (div_fin) begin
			div_pending <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- verilog/z_register.sv
`timescale 1ns/1ps
`default_nettype none

module z_register (
	input  wire                          clock,
	input  wire                          rst_n,
	input  wire alu_ctrl_pkg::result_s   res,
	input  wire                          res_valid,
	output alu_types_pkg::word_t         z_hi,
	output alu_types_pkg::word_t         z_lo,
	output logic                         done
);

	alu_ctrl_pkg::result_s z_q;

	// Always ready, loads whenever a result shows up
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			z_q  <= '0;
			done <= 1'b0;
		end else begin
			// Done one cycle behind the load edge
			done <= res_valid;
			if (res_valid) begin
				z_q <= res;
			end
		end
	end

	// Halves read separately by the CPU
	assign z_hi = z_q.hi;
	assign z_lo = z_q.lo;

endmodule

`default_nettype wire

//--- verilog/alu_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module alu_datapath (
	input  wire                          clock,
	input  wire                          rst_n,
	input  wire alu_types_pkg::word_t    bus,
	input  wire                          y_in,
	input  wire                          start,
	input  wire alu_types_pkg::alu_op_t  op,
	output alu_types_pkg::word_t         z_hi,
	output alu_types_pkg::word_t         z_lo,
	output logic                         done,
	output logic                         busy
);

	alu_types_pkg::operand_s opnd;
	logic opnd_valid;
	alu_ctrl_pkg::result_s res;
	logic res_valid;

	// Operands in, Y held here
	operand_stage u_opnd (
		.clock      (clock),
		.rst_n      (rst_n),
		.bus        (bus),
		.y_in       (y_in),
		.start      (start),
		.op         (op),
		.busy       (busy),
		.opnd       (opnd),
		.opnd_valid (opnd_valid)
	);

	alu u_alu (
		.clock      (clock),
		.rst_n      (rst_n),
		.opnd       (opnd),
		.opnd_valid (opnd_valid),
		.res        (res),
		.res_valid  (res_valid),
		.busy       (busy)
	);

	// Z holds the 64-bit result
	z_register u_z (
		.clock     (clock),
		.rst_n     (rst_n),
		.res       (res),
		.res_valid (res_valid),
		.z_hi      (z_hi),
		.z_lo      (z_lo),
		.done      (done)
	);

endmodule

`default_nettype wire

//--- tests/alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu_tb;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 8;

	// Operation counts per section that size the watchdog
	localparam int LOGIC_RANDOM = 8;
	localparam int ARITH_RANDOM = 8;
	localparam int MUL_RANDOM = 16;
	localparam int DIV_RANDOM = 16;
	localparam int NUM_TESTS = 4 * (4 + LOGIC_RANDOM) + (6 + 2 * ARITH_RANDOM)
		+ 5 * 32 + (8 + MUL_RANDOM) + (10 + DIV_RANDOM) + 3;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 40 + RESET_CYCLES + 100;

	// Z load edge counted from the start edge
	localparam int LAT_SINGLE = 1;
	localparam int LAT_DIV = 1 + 1 + `DIV_STEPS + 1;

	logic clock;
	logic rst_n;
	alu_types_pkg::word_t bus;
	logic y_in;
	logic start;
	alu_types_pkg::alu_op_t op;
	alu_types_pkg::word_t z_hi;
	alu_types_pkg::word_t z_lo;
	logic done;
	logic busy;

	// Expected Z values with the oldest first
	alu_types_pkg::dword_t expect_q[$];
	int ops_checked;

	alu_datapath UUT (
		.clock (clock),
		.rst_n (rst_n),
		.bus   (bus),
		.y_in  (y_in),
		.start (start),
		.op    (op),
		.z_hi  (z_hi),
		.z_lo  (z_lo),
		.done  (done),
		.busy  (busy)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_value(
		input string       name,
		input logic [63:0] actual,
		input logic [63:0] expected
	);
		if (actual !== expected) begin
			$display("ERR %s: actual 0x%h expected 0x%h", name, actual, expected);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	// Expected 64-bit Z straight from the opcode definitions
	function automatic alu_types_pkg::dword_t alu_ref(
		input alu_types_pkg::alu_op_t code,
		input alu_types_pkg::word_t   y,
		input alu_types_pkg::word_t   b
	);
		longint sy;
		longint sb;
		longint q;
		longint r;
		int sh;
		alu_types_pkg::word_t lo;
		sy = $signed(y);
		sb = $signed(b);
		sh = int'(b[`SHAMT_W-1:0]);
		lo = '0;
		case (code)
			alu_types_pkg::OP_AND:  lo = y & b;
			alu_types_pkg::OP_OR:   lo = y | b;
			alu_types_pkg::OP_NEG:  lo = 32'd0 - y;
			alu_types_pkg::OP_NOT:  lo = ~y;
			alu_types_pkg::OP_ADD:  lo = y + b;
			alu_types_pkg::OP_SUB:  lo = y - b;
			// Full signed product
			alu_types_pkg::OP_MUL:  return sy * sb;
			alu_types_pkg::OP_DIV: begin
				// Divide by zero gives an all-ones quotient and keeps the dividend
				if (b == '0) begin
					return {y, 32'hffffffff};
				end
				// 64-bit math keeps 0x80000000 / -1 defined
				q = sy / sb;
				r = sy % sb;
				return {r[31:0], q[31:0]};
			end
			alu_types_pkg::OP_SHR:  lo = y >> sh;
			alu_types_pkg::OP_SHRA: lo = $signed(y) >>> sh;
			alu_types_pkg::OP_SHL:  lo = y << sh;
			alu_types_pkg::OP_ROR:  lo = (y >> sh) | (y << (32 - sh));
			alu_types_pkg::OP_ROL:  lo = (y << sh) | (y >> (32 - sh));
			default:                lo = '0;
		endcase
		return {32'h0, lo};
	endfunction

	// Load Y, launch one op, wait for done and check the timing
	task automatic run_op(
		input alu_types_pkg::alu_op_t code,
		input alu_types_pkg::word_t   y,
		input alu_types_pkg::word_t   b
	);
		int edges;
		int lat;
		lat = (code == alu_types_pkg::OP_DIV) ? LAT_DIV : LAT_SINGLE;
		expect_q.push_back(alu_ref(code, y, b));
		@(negedge clock);
		bus = y;
		y_in = 1'b1;
		@(negedge clock);
		y_in = 1'b0;
		bus = b;
		op = code;
		start = 1'b1;
		// Start edge
		@(posedge clock);
		@(negedge clock);
		start = 1'b0;
		// Bus moves on while the captured operands must stay
		bus = $urandom;
		edges = 0;
		while (!done) begin
			check_value("busy", busy, 64'd1);
			@(posedge clock);
			edges++;
			@(negedge clock);
			if (edges > LAT_DIV + 4) begin
				abort_run("done never arrived after a start pulse");
			end
		end
		check_value("done_latency", edges, lat);
		check_value("busy", busy, 64'd0);
		ops_checked++;
	endtask

	// Compares Z against the oldest expected value on each done
	always @(negedge clock) begin
		alu_types_pkg::dword_t exp_z;
		if (rst_n && done) begin
			if (expect_q.size() == 0) begin
				abort_run("done pulsed with no operation outstanding");
			end
			exp_z = expect_q.pop_front();
			check_value("z_hi", z_hi, exp_z[63:32]);
			check_value("z_lo", z_lo, exp_z[31:0]);
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("timeout, the test sequence did not finish in time");
	end

	initial begin
		alu_types_pkg::alu_op_t code;
		alu_types_pkg::word_t y;
		alu_types_pkg::word_t b;
		void'($urandom(32'h510b));
		ops_checked = 0;
		rst_n = 1'b0;
		bus = '0;
		y_in = 1'b0;
		start = 1'b0;
		op = alu_types_pkg::OP_AND;
		repeat (RESET_CYCLES) @(negedge clock);
		rst_n = 1'b1;
		@(negedge clock);
		check_value("done", done, 64'd0);
		check_value("busy", busy, 64'd0);
		check_value("z_hi", z_hi, 64'd0);
		check_value("z_lo", z_lo, 64'd0);

		// AND, OR, NEG, NOT
		for (int k = 0; k < 4; k++) begin
			code = alu_types_pkg::alu_op_t'(k);
			run_op(code, 32'h0, 32'h0);
			run_op(code, 32'hffffffff, 32'hffffffff);
			run_op(code, 32'h0, 32'hffffffff);
			run_op(code, 32'hffffffff, 32'h0);
			repeat (LOGIC_RANDOM) run_op(code, $urandom, $urandom);
		end

		// Wraparound corners first
		run_op(alu_types_pkg::OP_ADD, 32'h7fffffff, 32'h1);
		run_op(alu_types_pkg::OP_ADD, 32'hffffffff, 32'h1);
		run_op(alu_types_pkg::OP_ADD, 32'h80000000, 32'h80000000);
		run_op(alu_types_pkg::OP_SUB, 32'h0, 32'h1);
		run_op(alu_types_pkg::OP_SUB, 32'h80000000, 32'h1);
		run_op(alu_types_pkg::OP_SUB, 32'h7fffffff, 32'hffffffff);
		repeat (ARITH_RANDOM) run_op(alu_types_pkg::OP_ADD, $urandom, $urandom);
		repeat (ARITH_RANDOM) run_op(alu_types_pkg::OP_SUB, $urandom, $urandom);

		// Every amount with junk in the upper bits of b
		for (int k = 8; k <= 12; k++) begin
			code = alu_types_pkg::alu_op_t'(k);
			for (int s = 0; s < 32; s++) begin
				y = $urandom;
				// Negative y on odd amounts for SHRA sign fill
				if (s % 2 == 1) begin
					y[31] = 1'b1;
				end
				b = ($urandom & 32'hffffffe0) | 32'(s);
				run_op(code, y, b);
			end
		end

		// Multiplier extremes
		run_op(alu_types_pkg::OP_MUL, 32'h80000000, 32'h80000000);
		run_op(alu_types_pkg::OP_MUL, 32'h7fffffff, 32'h7fffffff);
		run_op(alu_types_pkg::OP_MUL, 32'h80000000, 32'h7fffffff);
		run_op(alu_types_pkg::OP_MUL, 32'hffffffff, 32'hffffffff);
		run_op(alu_types_pkg::OP_MUL, 32'hffffffff, 32'h1);
		run_op(alu_types_pkg::OP_MUL, 32'h0, 32'h12345678);
		run_op(alu_types_pkg::OP_MUL, 32'h80000000, 32'h1);
		run_op(alu_types_pkg::OP_MUL, 32'h80000000, 32'hffffffff);
		repeat (MUL_RANDOM) run_op(alu_types_pkg::OP_MUL, $urandom, $urandom);

		// Sign mixes and divide by zero
		run_op(alu_types_pkg::OP_DIV, 32'd100, 32'd7);
		run_op(alu_types_pkg::OP_DIV, -32'd100, 32'd7);
		run_op(alu_types_pkg::OP_DIV, 32'd100, -32'd7);
		run_op(alu_types_pkg::OP_DIV, -32'd100, -32'd7);
		run_op(alu_types_pkg::OP_DIV, 32'd5, 32'd0);
		run_op(alu_types_pkg::OP_DIV, -32'd5, 32'd0);
		run_op(alu_types_pkg::OP_DIV, 32'h80000000, 32'hffffffff);
		run_op(alu_types_pkg::OP_DIV, 32'h7fffffff, 32'd1);
		run_op(alu_types_pkg::OP_DIV, 32'd3, 32'd10);
		run_op(alu_types_pkg::OP_DIV, 32'h80000000, 32'd1);
		for (int k = 0; k < DIV_RANDOM; k++) begin
			y = $urandom;
			b = $urandom;
			// Half with small divisors so quotients get large
			if (k % 2 == 0) begin
				b = ($urandom % 1000) + 1;
				if ($urandom % 2 == 1) begin
					b = -b;
				end
			end
			run_op(alu_types_pkg::OP_DIV, y, b);
		end

		// Codes 13 to 15 have no operation
		run_op(alu_types_pkg::alu_op_t'(4'd13), $urandom, $urandom);
		run_op(alu_types_pkg::alu_op_t'(4'd14), $urandom, $urandom);
		run_op(alu_types_pkg::alu_op_t'(4'd15), $urandom, $urandom);

		// Let the compare process drain
		repeat (4) @(negedge clock);
		$display("%0d operations checked", ops_checked);
		if (expect_q.size() != 0) begin
			$display("%0d expected results were never compared", expect_q.size());
			$display("Finished with errors");
			$fatal(1);
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verilog
verilog/alu_types_pkg.sv
verilog/alu_ctrl_pkg.sv
verilog/operand_stage.sv
verilog/bit_pair_multiplier.sv
verilog/nonrestoring_divider.sv
verilog/alu.sv
verilog/z_register.sv
verilog/alu_datapath.sv
tests/alu_tb.sv
